//--- dv/soc_assert.sv
module soc_assert (
    input logic clk,
    input logic rst_n_i,
    input logic mem_valid_i,
    input logic mem_ready_i,
    input logic sram_ready_i,
    input logic tick_ready_i,
    input logic flash_ready_i,
    input logic hit_i,
    input logic miss_i,
    input logic irq_i
);

    // sampled mid-cycle, where the bus is stable.
    slave_ready_needs_valid: assert property (@(negedge clk) disable iff (!rst_n_i)
        (sram_ready_i || tick_ready_i || flash_ready_i) |-> mem_valid_i)
        else $error("slave ready seen without valid.");

    hit_miss_exclusive: assert property (@(negedge clk) disable iff (!rst_n_i)
        !(hit_i && miss_i))
        else $error("hit and miss high together.");

    flag_needs_ready: assert property (@(negedge clk) disable iff (!rst_n_i)
        (hit_i || miss_i) |-> mem_ready_i)
        else $error("hit or miss without ready.");

    irq_low_in_reset: assert property (@(negedge clk)
        !rst_n_i |-> !irq_i)
        else $error("irq high during reset.");

endmodule

bind soc_top soc_assert u_assert (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .mem_valid_i   (mem_valid_i),
    .mem_ready_i   (mem_ready_o),
    .sram_ready_i  (sram_ready),
    .tick_ready_i  (tick_ready),
    .flash_ready_i (flash_ready),
    .hit_i         (cache_hit_o),
    .miss_i        (cache_miss_o),
    .irq_i         (irq_o)
);

//--- dv/soc_tb.sv
`include "soc_defs.svh"

module soc_tb;
    import soc_pkg::*;

    localparam int RAND_COUNT = 64;
    localparam int TAG_LINES  = `CACHE_LINES;

    logic       clk;
    logic       rst_n_i;
    logic       mem_valid_i;
    addr_t      mem_addr_i;
    word_t      mem_wdata_i;
    strb_t      mem_wstrb_i;
    logic       mem_ready_o;
    word_t      mem_rdata_o;
    logic [5:0] leds_o;
    logic       irq_o;
    logic       cache_hit_o;
    logic       cache_miss_o;

    int         cycles;
    int         limit;

    // trace contents.
    byte        op_q[$];
    addr_t      addr_q[$];
    word_t      data_q[$];
    strb_t      strb_q[$];
    word_t      exp_q[$];

    // reference models.
    logic       tag_valid [TAG_LINES];
    int         tag_mem [TAG_LINES];
    word_t      led_model;
    word_t      sram_model [addr_t];

    soc_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .mem_valid_i  (mem_valid_i),
        .mem_addr_i   (mem_addr_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_wstrb_i  (mem_wstrb_i),
        .mem_ready_o  (mem_ready_o),
        .mem_rdata_o  (mem_rdata_o),
        .leds_o       (leds_o),
        .irq_o        (irq_o),
        .cache_hit_o  (cache_hit_o),
        .cache_miss_o (cache_miss_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation ran past its limit of %0d cycles", limit);
        stop_on_error();
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error.");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Fail %s exp %h act %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s exp %b act %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_leds(input string name, input logic [5:0] exp, input logic [5:0] act);
        if (act !== exp) begin
            $display("Fail %s exp %b act %b", name, exp, act);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t apply_strobes(input word_t old_w, input word_t new_w,
                                            input strb_t strb);
        word_t res;
        res = old_w;
        if (strb[0]) res[7:0]   = new_w[7:0];
        if (strb[1]) res[15:8]  = new_w[15:8];
        if (strb[2]) res[23:16] = new_w[23:16];
        if (strb[3]) res[31:24] = new_w[31:24];
        return res;
    endfunction

    // entered and left on a falling edge, with one idle cycle after ready.
    task automatic bus_access(input addr_t a, input word_t d, input strb_t s,
                              output word_t rd, output int lat,
                              output logic hit, output logic miss);
        lat         = 0;
        mem_valid_i = 1'b1;
        mem_addr_i  = a;
        mem_wdata_i = d;
        mem_wstrb_i = s;
        do begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end while (!mem_ready_o);
        rd          = mem_rdata_o;
        hit         = cache_hit_o;
        miss        = cache_miss_o;
        mem_valid_i = 1'b0;
        mem_wstrb_i = '0;
        @(negedge clk);
    endtask

    task automatic read_trace();
        int    fd;
        int    n;
        string line;
        byte   op;
        word_t a;
        word_t d;
        word_t s;
        word_t e;
        fd = $fopen("dv/soc_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/soc_trace.txt");
            stop_on_error();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%c %h %h %h %h", op, a, d, s, e);
            if (n == 5) begin
                op_q.push_back(op);
                addr_q.push_back(a);
                data_q.push_back(d);
                strb_q.push_back(s[3:0]);
                exp_q.push_back(e);
            end else begin
                $display("the trace file holds a line that could not be parsed");
                stop_on_error();
            end
        end
        $fclose(fd);
    endtask

    // predicts hit or miss of a flash read and updates the tag model.
    function automatic logic predict_hit(input addr_t a);
        int widx;
        int idx;
        int tag;
        logic hit;
        widx = int'(a[16:2]);
        idx  = widx % TAG_LINES;
        tag  = widx / TAG_LINES;
        hit  = tag_valid[idx] && (tag_mem[idx] == tag);
        tag_valid[idx] = 1'b1;
        tag_mem[idx]   = tag;
        return hit;
    endfunction

    task automatic run_trace();
        word_t rd;
        int    lat;
        int    waited;
        int    exp_lat;
        logic  hit;
        logic  miss;
        logic  exp_hit;
        logic  exp_miss;
        logic  is_flash;
        string name;
        for (int i = 0; i < op_q.size(); i++) begin
            name = $sformatf("trace %0d %c %h", i, op_q[i], addr_q[i]);
            if (op_q[i] == "T") begin
                waited = 0;
                while (irq_o !== exp_q[i][0] && waited < int'(data_q[i])) begin
                    @(negedge clk);
                    waited++;
                end
                check_flag({name, " irq"}, exp_q[i][0], irq_o);
                continue;
            end
            is_flash = (addr_q[i] <= `FLASH_END);
            exp_hit  = 1'b0;
            exp_miss = 1'b0;
            exp_lat  = 1;
            if (is_flash && op_q[i] == "R") begin
                exp_hit  = predict_hit(addr_q[i]);
                exp_miss = ~exp_hit;
                exp_lat  = exp_hit ? 1 : `FLASH_WAIT + 2;
            end else if (is_flash) begin
                exp_lat  = `FLASH_WAIT + 2;
            end
            if (op_q[i] == "W") begin
                bus_access(addr_q[i], data_q[i], strb_q[i], rd, lat, hit, miss);
                if (addr_q[i] == `LEDS_ADDR) begin
                    led_model = apply_strobes(led_model, data_q[i], strb_q[i]);
                end
            end else begin
                bus_access(addr_q[i], '0, '0, rd, lat, hit, miss);
                check_word({name, " rdata"}, exp_q[i], rd);
            end
            check_word({name, " cycles"}, word_t'(exp_lat), word_t'(lat));
            check_flag({name, " hit"}, exp_hit, hit);
            check_flag({name, " miss"}, exp_miss, miss);
            check_leds({name, " leds"}, ~led_model[5:0], leds_o);
        end
    endtask

    task automatic run_random_sram();
        logic [31:0] rng;
        addr_t       a;
        word_t       d;
        word_t       rd;
        strb_t       s;
        int          lat;
        logic        hit;
        logic        miss;
        string       name;
        rng = 32'h2aae_8551;
        for (int i = 0; i < RAND_COUNT; i++) begin
            rng = xorshift32(rng);
            // 16 words spread over the array, so most writes land on written words.
            a   = `SRAM_BASE + {19'b0, rng[12:11], 7'b0, rng[3:2], 2'b00};
            rng = xorshift32(rng);
            d   = rng;
            rng = xorshift32(rng);
            s   = rng[3:0];
            if (s == 4'h0) s = 4'h3;
            if (!sram_model.exists(a)) s = 4'hF;    // first write fills the word.
            name = $sformatf("sram %0d %h", i, a);
            bus_access(a, d, s, rd, lat, hit, miss);
            check_word({name, " write cycles"}, 32'd1, word_t'(lat));
            sram_model[a] = apply_strobes(sram_model.exists(a) ? sram_model[a] : '0, d, s);
            bus_access(a, '0, '0, rd, lat, hit, miss);
            check_word({name, " read cycles"}, 32'd1, word_t'(lat));
            check_word({name, " rdata"}, sram_model[a], rd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        limit       = 0;
        rst_n_i     = 1'b0;
        mem_valid_i = 1'b0;
        mem_addr_i  = '0;
        mem_wdata_i = '0;
        mem_wstrb_i = '0;
        led_model   = '0;
        for (int i = 0; i < TAG_LINES; i++) begin
            tag_valid[i] = 1'b0;
            tag_mem[i]   = 0;
        end

        read_trace();
        limit = op_q.size() * (`FLASH_WAIT + 4) + 4 * RAND_COUNT + 200;

        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_leds("reset leds", 6'h3F, leds_o);
        check_flag("reset irq", 1'b0, irq_o);

        run_trace();
        run_random_sram();

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- dv/soc_trace.txt
# op addr data strb exp, all hex; W write, R read and compare with exp
# T waits up to data cycles for irq_o to equal exp
W 80000000 0000002a 1 00000000
R 80000000 00000000 0 0000002a
W 80000000 0000ff15 2 00000000
R 80000000 00000000 0 0000ff2a
W 00000010 11112222 f 00000000
W 00000030 33334444 f 00000000
R 00000010 00000000 0 11112222
R 00000010 00000000 0 11112222
R 00000030 00000000 0 33334444
R 00000010 00000000 0 11112222
W 00000010 aabb0000 c 00000000
R 00000010 00000000 0 aabb2222
W 80000104 00000014 f 00000000
W 80000100 00000003 1 00000000
T 00000000 00000016 0 00000001
R 8000010c 00000000 0 00000001
W 8000010c 00000001 1 00000000
T 00000000 00000001 0 00000000
W 80000100 00000000 1 00000000
R 40000000 00000000 0 00000000

//--- files.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/flash_macro.sv
rtl/flash_cache.sv
rtl/sram_slave.sv
rtl/systick.sv
rtl/soc_interconnect.sv
rtl/soc_top.sv
dv/soc_assert.sv
dv/soc_tb.sv

//--- rtl/flash_cache.sv
`include "soc_defs.svh"

module flash_cache #(
    parameter int LINES = 8
) (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           sel_i,
    input  logic [14:0]    addr_i,      // word address.
    input  soc_pkg::word_t wdata_i,
    input  soc_pkg::strb_t wstrb_i,
    output logic           ready_o,
    output soc_pkg::word_t rdata_o,
    output logic           cache_hit_o,
    output logic           cache_miss_o
);
    import soc_pkg::*;

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = 15 - IDX_W;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FLASH_RD,
        FLASH_WR,
        RESP
    } state_e;

    state_e           state_q;
    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [LINES];
    word_t            data_q [LINES];
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             is_write;
    logic             tag_match;
    logic             hit_now;
    logic             fill;
    logic             wr_done;
    logic             mac_start;
    logic             mac_done;
    word_t            mac_rdata;

    assign idx       = addr_i[IDX_W-1:0];
    assign tag       = addr_i[14:IDX_W];
    assign is_write  = |wstrb_i;
    assign tag_match = valid_q[idx] & (tag_q[idx] == tag);
    assign hit_now   = (state_q == IDLE) & sel_i & ~is_write & tag_match;
    assign fill      = (state_q == FLASH_RD) & mac_done;
    assign wr_done   = (state_q == FLASH_WR) & mac_done;
    assign mac_start = (state_q == LOOKUP);

    flash_macro #(
        .WAIT (`FLASH_WAIT)
    ) u_macro (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (mac_start),
        .write_i (is_write),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .wstrb_i (wstrb_i),
        .done_o  (mac_done),
        .rdata_o (mac_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            valid_q      <= '0;
            ready_o      <= 1'b0;
            cache_hit_o  <= 1'b0;
            cache_miss_o <= 1'b0;
        end else begin
            ready_o      <= hit_now | fill | wr_done;
            cache_hit_o  <= hit_now;
            cache_miss_o <= fill;
            case (state_q)
                IDLE: begin
                    if (hit_now)    state_q <= RESP;
                    else if (sel_i) state_q <= LOOKUP;
                end
                LOOKUP:   state_q <= is_write ? FLASH_WR : FLASH_RD;
                FLASH_RD: begin
                    if (mac_done) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= RESP;
                    end
                end
                FLASH_WR: if (mac_done) state_q <= RESP;
                RESP:     state_q <= IDLE;     // master drops or moves on.
                default:  state_q <= IDLE;
            endcase
        end
    end

    // writes never allocate, only patch a resident word.
    always_ff @(posedge clk) begin
        if (hit_now) rdata_o <= data_q[idx];
        if (fill) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mac_rdata;
            rdata_o     <= mac_rdata;
        end
        if (wr_done && tag_match) data_q[idx] <= merge_bytes(data_q[idx], wdata_i, wstrb_i);
    end

endmodule

//--- rtl/flash_macro.sv
module flash_macro #(
    parameter int WAIT = 4
) (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           start_i,
    input  logic           write_i,
    input  logic [14:0]    addr_i,
    input  soc_pkg::word_t wdata_i,
    input  soc_pkg::strb_t wstrb_i,
    output logic           done_o,
    output soc_pkg::word_t rdata_o
);
    import soc_pkg::*;

    localparam int DEPTH = 2 ** 15;
    localparam int CNT_W = $clog2(WAIT + 1);

    word_t             mem_q [DEPTH];
    logic [CNT_W-1:0]  cnt_q;
    logic              write_q;
    logic [14:0]       addr_q;
    word_t             wdata_q;
    strb_t             wstrb_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)           cnt_q <= '0;
        else if (start_i)       cnt_q <= CNT_W'(WAIT);
        else if (cnt_q != '0)   cnt_q <= cnt_q - CNT_W'(1);
    end

    assign done_o = (cnt_q == CNT_W'(1));  // last wait cycle.

    always_ff @(posedge clk) begin
        if (start_i) begin
            write_q <= write_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
            rdata_o <= mem_q[addr_i];
        end
        if (done_o && write_q) mem_q[addr_q] <= merge_bytes(mem_q[addr_q], wdata_q, wstrb_q);
    end

endmodule

//--- rtl/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// memory map
////////////////////////////////////////////////////////////////////////////

`define FLASH_BASE  32'h0000_0000
`define FLASH_END   32'h0001_2FFF
`define SRAM_BASE   32'h0002_0000
`define SRAM_END    32'h0002_1FFF
`define LEDS_ADDR   32'h8000_0000
`define TICK_BASE   32'h8000_0100
`define TICK_END    32'h8000_010F

// systick register offsets.
`define TICK_CTRL   4'h0
`define TICK_LOAD   4'h4
`define TICK_VAL    4'h8
`define TICK_STAT   4'hC

////////////////////////////////////////////////////////////////////////////
// sizing
////////////////////////////////////////////////////////////////////////////

`define FLASH_WAIT  4       // macro access wait in cycles.
`define CACHE_LINES 8
`define SRAM_AW     13      // byte address bits, 8 KiB.

`endif

//--- rtl/soc_interconnect.sv
`include "soc_defs.svh"

module soc_interconnect (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           mem_valid_i,
    input  soc_pkg::addr_t mem_addr_i,
    input  soc_pkg::word_t mem_wdata_i,
    input  soc_pkg::strb_t mem_wstrb_i,
    output logic           mem_ready_o,
    output soc_pkg::word_t mem_rdata_o,
    output logic           sram_sel_o,
    input  logic           sram_ready_i,
    input  soc_pkg::word_t sram_rdata_i,
    output logic           tick_sel_o,
    input  logic           tick_ready_i,
    input  soc_pkg::word_t tick_rdata_i,
    output logic           flash_sel_o,
    input  logic           flash_ready_i,
    input  soc_pkg::word_t flash_rdata_i,
    output logic [5:0]     leds_o
);
    import soc_pkg::*;

    slave_e slv;
    logic   local_sel;
    logic   local_ready_q;
    word_t  led_q;

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        slv = SLV_NONE;
        if ((mem_addr_i - `FLASH_BASE) <= (`FLASH_END - `FLASH_BASE)) begin
            slv = SLV_FLASH;
        end else if ((mem_addr_i - `SRAM_BASE) <= (`SRAM_END - `SRAM_BASE)) begin
            slv = SLV_SRAM;
        end else if (mem_addr_i == `LEDS_ADDR) begin
            slv = SLV_LEDS;
        end else if ((mem_addr_i - `TICK_BASE) <= (`TICK_END - `TICK_BASE)) begin
            slv = SLV_TICK;
        end
    end

    assign flash_sel_o = mem_valid_i & (slv == SLV_FLASH);
    assign sram_sel_o  = mem_valid_i & (slv == SLV_SRAM);
    assign tick_sel_o  = mem_valid_i & (slv == SLV_TICK);
    assign local_sel   = mem_valid_i & ((slv == SLV_LEDS) | (slv == SLV_NONE));

    // leds and unmapped holes answered here.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            local_ready_q <= 1'b0;
            led_q         <= '0;
        end else begin
            local_ready_q <= local_sel & ~local_ready_q;
            if (local_sel && !local_ready_q && (slv == SLV_LEDS)) begin
                led_q <= merge_bytes(led_q, mem_wdata_i, mem_wstrb_i);
            end
        end
    end

    assign mem_ready_o = mem_valid_i &
                         (sram_ready_i | tick_ready_i | flash_ready_i | local_ready_q);

    always_comb begin
        case (slv)
            SLV_FLASH: mem_rdata_o = flash_rdata_i;
            SLV_SRAM:  mem_rdata_o = sram_rdata_i;
            SLV_LEDS:  mem_rdata_o = led_q;
            SLV_TICK:  mem_rdata_o = tick_rdata_i;
            default:   mem_rdata_o = '0;    // unmapped reads as zero.
        endcase
    end

    assign leds_o = ~led_q[5:0];    // leds are active low.

endmodule

//--- rtl/soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;    // all zero is a read.

    typedef enum logic [2:0] {
        SLV_NONE,
        SLV_FLASH,
        SLV_SRAM,
        SLV_LEDS,
        SLV_TICK
    } slave_e;

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return res;
    endfunction

endpackage

//--- rtl/soc_top.sv
`include "soc_defs.svh"

module soc_top (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           mem_valid_i,
    input  soc_pkg::addr_t mem_addr_i,
    input  soc_pkg::word_t mem_wdata_i,
    input  soc_pkg::strb_t mem_wstrb_i,
    output logic           mem_ready_o,
    output soc_pkg::word_t mem_rdata_o,
    output logic [5:0]     leds_o,
    output logic           irq_o,
    output logic           cache_hit_o,
    output logic           cache_miss_o
);
    import soc_pkg::*;

    logic  sram_sel;
    logic  sram_ready;
    word_t sram_rdata;
    logic  tick_sel;
    logic  tick_ready;
    word_t tick_rdata;
    logic  flash_sel;
    logic  flash_ready;
    word_t flash_rdata;

    soc_interconnect u_xbar (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .mem_valid_i   (mem_valid_i),
        .mem_addr_i    (mem_addr_i),
        .mem_wdata_i   (mem_wdata_i),
        .mem_wstrb_i   (mem_wstrb_i),
        .mem_ready_o   (mem_ready_o),
        .mem_rdata_o   (mem_rdata_o),
        .sram_sel_o    (sram_sel),
        .sram_ready_i  (sram_ready),
        .sram_rdata_i  (sram_rdata),
        .tick_sel_o    (tick_sel),
        .tick_ready_i  (tick_ready),
        .tick_rdata_i  (tick_rdata),
        .flash_sel_o   (flash_sel),
        .flash_ready_i (flash_ready),
        .flash_rdata_i (flash_rdata),
        .leds_o        (leds_o)
    );

    sram_slave #(
        .ADDR_WIDTH (`SRAM_AW)
    ) u_sram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .sel_i   (sram_sel),
        .addr_i  (mem_addr_i[`SRAM_AW-1:0]),
        .wdata_i (mem_wdata_i),
        .wstrb_i (mem_wstrb_i),
        .ready_o (sram_ready),
        .rdata_o (sram_rdata)
    );

    systick u_tick (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .sel_i   (tick_sel),
        .addr_i  (mem_addr_i[3:0]),
        .wdata_i (mem_wdata_i),
        .wstrb_i (mem_wstrb_i),
        .ready_o (tick_ready),
        .rdata_o (tick_rdata),
        .irq_o   (irq_o)
    );

    flash_cache #(
        .LINES (`CACHE_LINES)
    ) u_flash (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .sel_i        (flash_sel),
        .addr_i       (mem_addr_i[16:2]),   // word address.
        .wdata_i      (mem_wdata_i),
        .wstrb_i      (mem_wstrb_i),
        .ready_o      (flash_ready),
        .rdata_o      (flash_rdata),
        .cache_hit_o  (cache_hit_o),
        .cache_miss_o (cache_miss_o)
    );

endmodule

//--- rtl/sram_slave.sv
module sram_slave #(
    parameter int ADDR_WIDTH = 13
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  sel_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  soc_pkg::word_t        wdata_i,
    input  soc_pkg::strb_t        wstrb_i,
    output logic                  ready_o,
    output soc_pkg::word_t        rdata_o
);
    import soc_pkg::*;

    localparam int DEPTH = 2 ** (ADDR_WIDTH - 2);

    word_t                 mem_q [DEPTH];
    logic [ADDR_WIDTH-3:0] word_idx;
    logic                  access;

    assign word_idx = addr_i[ADDR_WIDTH-1:2];
    assign access   = sel_i & ~ready_o;    // one pulse per request.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) ready_o <= 1'b0;
        else          ready_o <= access;
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_o <= mem_q[word_idx];
            if (|wstrb_i) mem_q[word_idx] <= merge_bytes(mem_q[word_idx], wdata_i, wstrb_i);
        end
    end

endmodule

//--- rtl/systick.sv
`include "soc_defs.svh"

module systick (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           sel_i,
    input  logic [3:0]     addr_i,
    input  soc_pkg::word_t wdata_i,
    input  soc_pkg::strb_t wstrb_i,
    output logic           ready_o,
    output soc_pkg::word_t rdata_o,
    output logic           irq_o
);
    import soc_pkg::*;

    logic [1:0] ctrl_q;     // bit 0 enable, bit 1 irq enable.
    word_t      load_q;
    word_t      val_q;
    logic       stat_q;
    logic       access;
    logic       wr;
    logic       wrap;
    word_t      load_new;

    assign access   = sel_i & ~ready_o;
    assign wr       = access & (|wstrb_i);
    assign wrap     = ctrl_q[0] & (val_q == '0);
    assign load_new = merge_bytes(load_q, wdata_i, wstrb_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_o <= 1'b0;
            ctrl_q  <= '0;
            load_q  <= '0;
            val_q   <= '0;
            stat_q  <= 1'b0;
        end else begin
            ready_o <= access;
            if (wr && (addr_i == `TICK_CTRL) && wstrb_i[0]) ctrl_q <= wdata_i[1:0];
            if (wr && (addr_i == `TICK_LOAD)) begin
                load_q <= load_new;
                val_q  <= load_new;     // load also restarts the count.
            end else if (ctrl_q[0]) begin
                val_q <= wrap ? load_q : val_q - 32'd1;
            end
            if (wrap) begin
                stat_q <= 1'b1;
            end else if (wr && (addr_i == `TICK_STAT) && wstrb_i[0] && wdata_i[0]) begin
                stat_q <= 1'b0;         // write one to clear.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (addr_i)
                `TICK_CTRL: rdata_o <= {30'b0, ctrl_q};
                `TICK_LOAD: rdata_o <= load_q;
                `TICK_VAL:  rdata_o <= val_q;
                `TICK_STAT: rdata_o <= {31'b0, stat_q};
                default:    rdata_o <= '0;
            endcase
        end
    end

    assign irq_o = stat_q & ctrl_q[1];

endmodule

//--- run.sh
#!/bin/sh
# build and run the soc testbench with verilator, then scan the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module soc_tb -o soc_sim \
    > build.log 2>&1 \
    && ./obj_dir/soc_sim > sim.log 2>&1 \
    || echo "=== FAIL ===" >> sim.log

grep -q "=== FAIL ===" sim.log \
    && { echo "simulation failed, see sim.log and build.log"; exit 1; } \
    || { grep -q "=== PASS ===" sim.log \
         && echo "simulation passed" \
         || { echo "no result in sim.log"; exit 1; }; }
